// File: run_sim.sh
#!/bin/sh
# builds the tsgen testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_tsgen_top -o sim_tsgen
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tsgen > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    exit 1
fi

exit 0

// File: source/channel_gain.sv
/* per-channel gain stage, selects the strobed channel byte and scales it
   gains are loaded through the gain bank of the config write port */
module channel_gain
(
    input  logic                clk_341m,
    input  logic                rst,
    input  tsgen_pkg::sched_t   sched,
    input  tsgen_pkg::ts_byte_t ts_bytes [tsgen_pkg::num_channels],
    input  tsgen_pkg::cfg_wr_t  cfg,
    output tsgen_pkg::sample_t  sample
);

    logic [tsgen_pkg::gain_width-1:0] gain [tsgen_pkg::num_channels];

    // select stage
    logic                sel_valid;
    tsgen_pkg::ch_t      sel_ch;
    tsgen_pkg::ts_byte_t sel_byte;

    // product stage
    logic                              out_valid;
    tsgen_pkg::ch_t                    out_ch;
    logic [tsgen_pkg::sample_width-1:0] out_value;

    // config decode, bb and mix banks are reserved and ignored
    always_ff @(posedge clk_341m or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < tsgen_pkg::num_channels; i++)
            begin
                gain[i] <= tsgen_pkg::gain_unity;
            end
        end
        else if (cfg.we)
        begin
            case (cfg.bank)
                tsgen_pkg::cfg_bank_gain:
                begin
                    gain[cfg.ch] <= cfg.data;
                end
                default:
                begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_341m or posedge rst)
    begin
        if (rst)
        begin
            sel_valid <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            sel_valid <= sched.valid;
            out_valid <= sel_valid;
        end
    end

    // payload path
    always_ff @(posedge clk_341m)
    begin
        sel_ch    <= sched.ch;
        sel_byte  <= ts_bytes[sched.ch];
        out_ch    <= sel_ch;
        // 8 x 8 product fills the 16-bit sample exactly
        out_value <= tsgen_pkg::sample_width'(sel_byte) *
                     tsgen_pkg::sample_width'(gain[sel_ch]);
    end

    assign sample.valid = out_valid;
    assign sample.ch    = out_ch;
    assign sample.value = out_value;

endmodule

// File: source/channel_scheduler.sv
/* round-robin read strobe source for the sixteen packet channels
   one strobe per cycle while run is high, channel held while run is low */
module channel_scheduler
(
    input  logic                clk_341m,
    input  logic                rst,
    input  logic                run,
    output tsgen_pkg::sched_t   sched
);

    tsgen_pkg::ch_t  ch_cnt;

    // channel steps after each strobe, wraps naturally after 15
    always_ff @(posedge clk_341m or posedge rst)
    begin
        if (rst)
        begin
            ch_cnt <= '0;
        end
        else if (run)
        begin
            ch_cnt <= ch_cnt + 1'b1;
        end
    end

    // a strobe in every cycle that run is high
    assign sched.valid = run;
    assign sched.ch    = ch_cnt;

endmodule

// File: source/sample_packer.sv
/* packs consecutive samples into two-lane dac words
   lane 0 is held across run pauses until its partner sample arrives */
module sample_packer
(
    input  logic                 clk_341m,
    input  logic                 rst,
    input  tsgen_pkg::sample_t   sample,
    output tsgen_pkg::dac_word_t dac_word,
    output logic                 word_valid
);

    typedef enum logic {
        phase_lane0 = 1'b0,
        phase_lane1 = 1'b1
    } load_phase_e;

    load_phase_e                        phase;
    tsgen_pkg::ch_t                     hold_ch;
    logic [tsgen_pkg::sample_width-1:0] hold_value;

    // load phase flips on every valid sample
    always_ff @(posedge clk_341m or posedge rst)
    begin
        if (rst)
        begin
            phase      <= phase_lane0;
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= sample.valid && (phase == phase_lane1);
            if (sample.valid)
            begin
                phase <= (phase == phase_lane0) ? phase_lane1 : phase_lane0;
            end
        end
    end

    // lane 0 capture and word assembly
    always_ff @(posedge clk_341m)
    begin
        if (sample.valid && (phase == phase_lane0))
        begin
            hold_ch    <= sample.ch;
            hold_value <= sample.value;
        end
        if (sample.valid && (phase == phase_lane1))
        begin
            dac_word.ch    <= hold_ch;
            dac_word.lane0 <= hold_value;
            dac_word.lane1 <= sample.value;
        end
    end

endmodule

// File: source/status_led.sv
/* heartbeat for the board led, inverts every toggle_cycles + 1 cycles */
module status_led
#(
    parameter int unsigned toggle_cycles = tsgen_pkg::led_toggle_cycles
)
(
    input  logic clk_341m,
    input  logic rst,
    output logic led_heartbeat
);

    logic [$clog2(toggle_cycles + 1)-1:0] cycle_cnt;
    logic                                 wrap;

    assign wrap = (cycle_cnt == $bits(cycle_cnt)'(toggle_cycles));

    always_ff @(posedge clk_341m or posedge rst)
    begin
        if (rst)
        begin
            cycle_cnt     <= '0;
            led_heartbeat <= 1'b0;
        end
        else if (wrap)
        begin
            cycle_cnt     <= '0;
            led_heartbeat <= ~led_heartbeat;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule

// File: source/ts_packet_gen.sv
/* packet byte source for one channel, 188-byte packets with a fixed header
   counter steps only on strobes naming this channel */
module ts_packet_gen
#(
    parameter int ch_index = 0
)
(
    input  logic                clk_341m,
    input  logic                rst,
    input  tsgen_pkg::sched_t   sched,
    output tsgen_pkg::ts_byte_t ts_byte
);

    logic [$clog2(tsgen_pkg::packet_bytes)-1:0] byte_cnt;
    logic                                        hit;

    assign hit = sched.valid && (sched.ch == tsgen_pkg::ch_t'(ch_index));

    // byte index within the packet
    always_ff @(posedge clk_341m or posedge rst)
    begin
        if (rst)
        begin
            byte_cnt <= '0;
        end
        else if (hit)
        begin
            if (byte_cnt == $bits(byte_cnt)'(tsgen_pkg::packet_bytes - 1))
            begin
                byte_cnt <= '0;
            end
            else
            begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // header for the first four bytes, then the index itself
    always_comb
    begin
        if (byte_cnt < 4)
        begin
            ts_byte = tsgen_pkg::ts_header[byte_cnt[1:0]];
        end
        else
        begin
            ts_byte = tsgen_pkg::ts_byte_t'(byte_cnt);
        end
    end

endmodule

// File: source/tsgen_pkg.sv
/* shared widths, counts and bus types of the transport-stream pattern source
   referenced by scoped name from every RTL file */
package tsgen_pkg;

    // channel and datapath sizes
    localparam int num_channels = 16;
    localparam int ch_width     = 4;
    localparam int byte_width   = 8;
    localparam int gain_width   = 8;
    localparam int sample_width = 16;

    // mpeg-ts packet length in bytes
    localparam int packet_bytes = 188;

    // sync byte sits at index 0, then the three fixed header bytes
    localparam logic [3:0][byte_width-1:0] ts_header = {8'h10, 8'h20, 8'h01, 8'h47};

    localparam logic [gain_width-1:0] gain_unity = 8'd1;

    // heartbeat half period in clk_341m cycles
    localparam int unsigned led_toggle_cycles = 5_000_000;

    typedef logic [ch_width-1:0]   ch_t;
    typedef logic [byte_width-1:0] ts_byte_t;

    // read strobe from the round-robin scheduler
    typedef struct packed {
        logic valid;
        ch_t  ch;
    } sched_t;

    // upper three bits of the config address select the bank
    typedef enum logic [2:0] {
        cfg_bank_bb   = 3'd0,
        cfg_bank_gain = 3'd1,
        cfg_bank_mix  = 3'd2
    } cfg_bank_e;

    // single-cycle config write
    typedef struct packed {
        logic                  we;
        cfg_bank_e             bank;
        ch_t                   ch;
        logic [gain_width-1:0] data;
    } cfg_wr_t;

    // scaled sample leaving the gain stage
    typedef struct packed {
        logic                    valid;
        ch_t                     ch;
        logic [sample_width-1:0] value;
    } sample_t;

    // two-lane dac word, ch tags lane 0
    typedef struct packed {
        ch_t                     ch;
        logic [sample_width-1:0] lane0;
        logic [sample_width-1:0] lane1;
    } dac_word_t;

endpackage

// File: source/tsgen_top.sv
/* sixteen-channel ts test pattern source for the dac board harness
   scheduler, packet generators, gain stage, packer and heartbeat led */
module tsgen_top
#(
    parameter int unsigned toggle_cycles = tsgen_pkg::led_toggle_cycles
)
(
    input  logic                 clk_341m,
    input  logic                 rst,
    input  logic                 run,
    input  tsgen_pkg::cfg_wr_t   cfg,
    output tsgen_pkg::dac_word_t dac_word,
    output logic                 word_valid,
    output logic                 led_heartbeat
);

    tsgen_pkg::sched_t   sched;
    tsgen_pkg::ts_byte_t ts_bytes [tsgen_pkg::num_channels];
    tsgen_pkg::sample_t  sample;

    channel_scheduler sched0
    (
        .clk_341m (clk_341m),
        .rst      (rst),
        .run      (run),
        .sched    (sched)
    );

    // one generator per channel, each watching the shared strobe
    for (genvar i = 0; i < tsgen_pkg::num_channels; i++)
    begin : gen_ch
        ts_packet_gen
        #(
            .ch_index (i)
        )
        gen0
        (
            .clk_341m (clk_341m),
            .rst      (rst),
            .sched    (sched),
            .ts_byte  (ts_bytes[i])
        );
    end

    channel_gain gain0
    (
        .clk_341m (clk_341m),
        .rst      (rst),
        .sched    (sched),
        .ts_bytes (ts_bytes),
        .cfg      (cfg),
        .sample   (sample)
    );

    sample_packer packer0
    (
        .clk_341m   (clk_341m),
        .rst        (rst),
        .sample     (sample),
        .dac_word   (dac_word),
        .word_valid (word_valid)
    );

    status_led
    #(
        .toggle_cycles (toggle_cycles)
    )
    led0
    (
        .clk_341m      (clk_341m),
        .rst           (rst),
        .led_heartbeat (led_heartbeat)
    );

endmodule

// File: sources.f
source/tsgen_pkg.sv
source/channel_scheduler.sv
source/ts_packet_gen.sv
source/channel_gain.sv
source/sample_packer.sv
source/status_led.sv
source/tsgen_top.sv
testbench/tb_tsgen_top.sv

// File: testbench/tb_tsgen_top.sv
/* testbench for tsgen_top, runs a reference model of the packet, gain and
   packing rules next to the DUT and checks words, word rate and heartbeat */
module tb_tsgen_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int led_period      = 21;
    localparam int first_word_wait = 5;
    localparam int reset_check     = 15;
    localparam int rate_cycles     = 48;
    localparam int pattern_cycles  = 2 * 16 * 188 + 64;
    localparam int gain_run_cycles = 16 * 24;
    localparam int bank_run_cycles = 256;
    localparam int pause_bursts    = 60;
    localparam int timeout_cycles  = 2 + reset_check + first_word_wait + rate_cycles
                                     + pattern_cycles + 2 * (4 + 6) + gain_run_cycles
                                     + bank_run_cycles + pause_bursts * (32 + 15)
                                     + 10 + 1000;

    logic                 clk_341m;
    logic                 rst;
    logic                 run;
    tsgen_pkg::cfg_wr_t   cfg;
    tsgen_pkg::dac_word_t dac_word;
    logic                 word_valid;
    logic                 led_heartbeat;

    int    error_count;
    int    words_checked;
    int    led_samples;
    string test_name;
    bit    check_even;
    logic [31:0] lfsr_state;

    // reference model state
    int                   model_ch;
    int                   model_cnt [16];
    int                   model_gain [16];
    bit                   has_lane0;
    int                   lane0_ch;
    logic [15:0]          lane0_value;
    logic [15:0]          model_value;
    tsgen_pkg::dac_word_t exp_word;
    tsgen_pkg::dac_word_t exp_q [$];
    int                   led_edges;

    tsgen_top
    #(
        .toggle_cycles (20)
    )
    dut0
    (
        .clk_341m      (clk_341m),
        .rst           (rst),
        .run           (run),
        .cfg           (cfg),
        .dac_word      (dac_word),
        .word_valid    (word_valid),
        .led_heartbeat (led_heartbeat)
    );

    initial
    begin
        clk_341m = 1'b0;
        forever #5 clk_341m = ~clk_341m;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // ts header first, then the byte index
    function automatic logic [7:0] expected_byte(input int idx);
        case (idx)
            0: return 8'h47;
            1: return 8'h01;
            2: return 8'h20;
            3: return 8'h10;
            default: return 8'(idx);
        endcase
    endfunction

    task automatic run_for(input int n);
        run <= 1'b1;
        repeat (n) @(posedge clk_341m);
    endtask

    task automatic idle_for(input int n);
        run <= 1'b0;
        repeat (n) @(posedge clk_341m);
    endtask

    task automatic write_cfg(input tsgen_pkg::cfg_bank_e bank, input logic [3:0] ch,
                             input logic [7:0] data);
        tsgen_pkg::cfg_wr_t w;
        w.we   = 1'b1;
        w.bank = bank;
        w.ch   = ch;
        w.data = data;
        cfg <= w;
        @(posedge clk_341m);
        cfg <= '0;
    endtask

    // model follows the run level and config writes the DUT samples at each edge
    always @(posedge clk_341m)
    begin
        if (rst)
        begin
            model_ch  = 0;
            has_lane0 = 1'b0;
            exp_q.delete();
            for (int i = 0; i < 16; i++)
            begin
                model_cnt[i]  = 0;
                model_gain[i] = 1;
            end
        end
        else
        begin
            if (run)
            begin
                model_value = 16'(expected_byte(model_cnt[model_ch]))
                              * 16'(model_gain[model_ch]);
                if (has_lane0)
                begin
                    exp_word.ch    = 4'(lane0_ch);
                    exp_word.lane0 = lane0_value;
                    exp_word.lane1 = model_value;
                    exp_q.push_back(exp_word);
                end
                else
                begin
                    lane0_ch    = model_ch;
                    lane0_value = model_value;
                end
                has_lane0 = !has_lane0;
                model_cnt[model_ch] = (model_cnt[model_ch] + 1) % 188;
                model_ch = (model_ch + 1) % 16;
            end
            if (cfg.we && cfg.bank == tsgen_pkg::cfg_bank_gain)
            begin
                model_gain[cfg.ch] = int'(cfg.data);
            end
            if (word_valid)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    error_count++;
                    $display("word_valid pulsed with no expected word in test %s", test_name);
                end
                if (exp_q.size() > 0)
                begin
                    exp_word = exp_q.pop_front();
                    words_checked++;
                    assert (dac_word == exp_word)
                    else
                    begin
                        error_count++;
                        $display("Error in test %s: expected word %h, actual %h",
                                 test_name, exp_word, dac_word);
                    end
                end
                if (check_even)
                begin
                    assert (dac_word.ch[0] == 1'b0)
                    else
                    begin
                        error_count++;
                        $display("Error in test %s: expected even lane 0 channel, actual %0d",
                                 test_name, dac_word.ch);
                    end
                end
            end
        end
    end

    // heartbeat level after n edges out of reset
    always @(posedge clk_341m)
    begin
        if (rst)
        begin
            led_edges = 0;
        end
        else
        begin
            assert (led_heartbeat == 1'((led_edges / led_period) % 2))
            else
            begin
                error_count++;
                $display("Error in test led_heartbeat: expected %0d, actual %0d",
                         (led_edges / led_period) % 2, led_heartbeat);
            end
            led_edges++;
            led_samples++;
        end
    end

    a_word_gap: assert property (@(posedge clk_341m) disable iff (rst)
                                 word_valid |=> !word_valid)
    else
    begin
        error_count++;
        $display("word_valid was high in two consecutive cycles in test %s", test_name);
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clk_341m);
        $display("watchdog expired after %0d cycles before the tests finished",
                 timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        int          wait_cycles;
        logic [31:0] r_ch;
        logic [31:0] r_data;
        logic [31:0] r_len;

        error_count   = 0;
        words_checked = 0;
        led_samples   = 0;
        check_even    = 1'b1;
        lfsr_state    = 32'hff66_0d63;
        test_name     = "reset_state";
        rst           = 1'b1;
        run           = 1'b0;
        cfg           = '0;

        repeat (2) @(posedge clk_341m);
        rst <= 1'b0;
        for (int i = 0; i < reset_check; i++)
        begin
            @(posedge clk_341m);
            assert (!word_valid && !led_heartbeat)
            else
            begin
                error_count++;
                $display("Error in test %s: expected word_valid 0 led 0, actual %0d %0d",
                         test_name, word_valid, led_heartbeat);
            end
        end

        // strobe cycle, two gain stages, the pair's second sample, packer register
        test_name = "word_rate";
        run <= 1'b1;
        wait_cycles = 0;
        do
        begin
            @(posedge clk_341m);
            wait_cycles++;
        end
        while (!word_valid && wait_cycles < 20);
        assert (wait_cycles == first_word_wait)
        else
        begin
            error_count++;
            $display("Error in test %s: expected first word after %0d cycles, actual %0d",
                     test_name, first_word_wait, wait_cycles);
        end
        for (int i = 0; i < rate_cycles; i++)
        begin
            @(posedge clk_341m);
            assert (word_valid == 1'(i % 2))
            else
            begin
                error_count++;
                $display("Error in test %s: expected word_valid %0d, actual %0d",
                         test_name, i % 2, word_valid);
            end
        end

        test_name = "packet_pattern";
        run_for(pattern_cycles);
        assert (words_checked >= 16 * 188)
        else
        begin
            error_count++;
            $display("too few words seen to cover two packets on every channel");
        end

        test_name = "gain_writes";
        idle_for(4);
        for (int i = 0; i < 6; i++)
        begin
            take_bits(4, r_ch);
            take_bits(8, r_data);
            write_cfg(tsgen_pkg::cfg_bank_gain, r_ch[3:0], r_data[7:0]);
        end
        run_for(gain_run_cycles);

        test_name = "bank_decode";
        idle_for(4);
        for (int i = 0; i < 6; i++)
        begin
            take_bits(4, r_ch);
            take_bits(8, r_data);
            write_cfg(i[0] ? tsgen_pkg::cfg_bank_mix : tsgen_pkg::cfg_bank_bb,
                      r_ch[3:0], r_data[7:0]);
        end
        run_for(bank_run_cycles);

        // odd bursts leave half words held over a pause
        test_name  = "pause_resume";
        check_even = 1'b0;
        for (int i = 0; i < pause_bursts; i++)
        begin
            take_bits(5, r_len);
            run_for(int'(r_len) + 1);
            take_bits(4, r_len);
            idle_for(int'(r_len));
        end
        idle_for(10);
        assert (exp_q.size() == 0)
        else
        begin
            error_count++;
            $display("%0d expected words were never produced", exp_q.size());
        end

        $display("%0d errors, %0d words compared, %0d led samples",
                 error_count, words_checked, led_samples);
        if (error_count == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
